//--- pow_unit_top.f
+incdir+verilog
verilog/pow_pkg.sv
verilog/disp_pkg.sv
verilog/pow_pipeline.sv
verilog/pow_iterative.sv
verilog/pow_disp_driver.sv
verilog/pow_unit_top.sv
tb/tb_pow_unit_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pow_unit_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_pow_unit_top \
    -f pow_unit_top.f \
    -o sim_pow_unit_top

./obj_dir/sim_pow_unit_top | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "result: pass"
else
    echo "result: fail"
    exit 1
fi

//--- tb/tb_pow_unit_top.sv
`timescale 1ns/1ps
`include "pow_config.svh"

module tb_pow_unit_top
    import pow_pkg::*, disp_pkg::*;
();

    localparam int MAX_POW  = `POW_STAGES + 1;
    // result register loads POW_STAGES edges after acceptance and is taken on the next
    localparam int LAT      = `POW_STAGES + 1;
    localparam int PIPE_OPS = 200;
    localparam int BP_OPS   = 150;
    localparam int ITER_OPS = 60;
    // summed cycle cost of all tests with the burst at about half rate
    localparam int TEST_CYC = PIPE_OPS + LAT + 2 * BP_OPS + ITER_OPS * (LAT + 5) + 10;
    localparam int MAX_CYC  = 3 * TEST_CYC + 200;

    logic clk, rst_n;
    logic i_pipe_valid, o_pipe_ready, o_res_valid, i_res_ready;
    logic i_iter_valid, o_iter_ready, o_iter_res_valid, i_iter_res_ready;
    operand_t i_pipe_n, o_res, i_iter_n, o_iter_res;
    logic [`POW_STAGES * `POW_W - 1:0] o_disp;
    digit_en_t o_disp_en;
    dot_t      o_disp_dot;

    pow_lanes_u disp_view;
    int         cyc, chk_cnt, err_cnt, pipe_res_cnt, iter_res_cnt, iter_acc_cyc;
    operand_t   pipe_q [$];
    int         pipe_t [$];
    operand_t   iter_n;
    bit         lat_check, bp_mode, iter_busy, iter_seen, iter_ready_due;

    pow_unit_top u_dut
    (
        .clk              ( clk              ),
        .rst_n            ( rst_n            ),
        .i_pipe_valid     ( i_pipe_valid     ),
        .i_pipe_n         ( i_pipe_n         ),
        .o_pipe_ready     ( o_pipe_ready     ),
        .o_res_valid      ( o_res_valid      ),
        .o_res            ( o_res            ),
        .i_res_ready      ( i_res_ready      ),
        .i_iter_valid     ( i_iter_valid     ),
        .i_iter_n         ( i_iter_n         ),
        .o_iter_ready     ( o_iter_ready     ),
        .o_iter_res_valid ( o_iter_res_valid ),
        .o_iter_res       ( o_iter_res       ),
        .i_iter_res_ready ( i_iter_res_ready ),
        .o_disp           ( o_disp           ),
        .o_disp_en        ( o_disp_en        ),
        .o_disp_dot       ( o_disp_dot       )
    );

    assign disp_view = o_disp;

    always #4 clk = ~clk;

    // ----------------------------------------
    // reference model and checks
    // ----------------------------------------

    function automatic operand_t pow_ref(input operand_t x, input int e);
        int unsigned p;
        p = 1;
        for (int i = 0; i < e; i++)
            p = (p * 32'(x)) % (1 << `POW_W);
        return operand_t'(p);
    endfunction

    function automatic operand_t pow5_ref(input operand_t x);
        return pow_ref(x, 5);
    endfunction

    task automatic compare_byte(input string name, input operand_t got, input operand_t exp);
        chk_cnt++;
        assert (got == exp)
        else
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        chk_cnt++;
        assert (cond)
        else
        begin
            $display("error: %s", what);
            err_cnt++;
        end
    endtask

    // offer one operand and hold it until the pipeline takes it
    task automatic send_pipe(input operand_t x);
        i_pipe_valid = 1'b1;
        i_pipe_n     = x;
        @(posedge clk);
        while (!o_pipe_ready)
            @(posedge clk);
        @(negedge clk);
    endtask

    // ----------------------------------------
    // scoreboards sampled on the rising edge
    // ----------------------------------------

    always @(posedge clk)
    begin
        operand_t exp_n;
        int       acc_cyc;
        if (rst_n)
        begin
            if (i_pipe_valid && o_pipe_ready)
            begin
                pipe_q.push_back(i_pipe_n);
                pipe_t.push_back(cyc);
            end
            if (o_res_valid && !i_res_ready)
                expect_true(!o_pipe_ready, "o_pipe_ready high while the output is stalled");
            if (o_res_valid && i_res_ready)
            begin
                if (pipe_q.size() == 0)
                begin
                    expect_true(1'b0, "pipeline result with no operand outstanding");
                end
                else
                begin
                    exp_n   = pipe_q.pop_front();
                    acc_cyc = pipe_t.pop_front();
                    compare_byte("o_res", o_res, pow5_ref(exp_n));
                    if (lat_check)
                        expect_true(cyc - acc_cyc == LAT, "pipeline result latency is wrong");
                    pipe_res_cnt++;
                end
            end

            // iterative engine takes one operand at a time
            if (iter_ready_due)
            begin
                expect_true(o_iter_ready, "o_iter_ready not back after the result was taken");
                iter_ready_due = 1'b0;
            end
            if (iter_busy)
            begin
                expect_true(!o_iter_ready, "o_iter_ready high while an operand is in flight");
                if (o_iter_res_valid && !iter_seen)
                begin
                    expect_true(cyc - iter_acc_cyc == LAT, "iterative result latency is wrong");
                    iter_seen = 1'b1;
                end
                if (o_iter_res_valid && i_iter_res_ready)
                begin
                    compare_byte("o_iter_res", o_iter_res, pow5_ref(iter_n));
                    iter_busy      = 1'b0;
                    iter_ready_due = 1'b1;
                    iter_res_cnt++;
                end
            end
            else if (o_iter_res_valid)
            begin
                expect_true(1'b0, "iterative result with no operand accepted");
            end
            if (i_iter_valid && o_iter_ready)
            begin
                iter_busy    = 1'b1;
                iter_seen    = 1'b0;
                iter_n       = i_iter_n;
                iter_acc_cyc = cyc;
            end
        end
    end

    // pipeline result ready is random only during the burst
    always @(negedge clk)
        i_res_ready = bp_mode ? (($urandom() % 2) == 1) : 1'b1;

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYC)
        begin
            $display("timeout, run stopped after %0d cycles", cyc);
            $display("checks %0d, errors %0d", chk_cnt, err_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    initial
    begin
        operand_t x;
        operand_t corner [5];
        corner = '{8'h00, 8'h01, 8'h02, 8'h03, 8'hff};
        void'($urandom(32'hc2f8));
        clk              = 1'b0;
        rst_n            = 1'b0;
        i_pipe_valid     = 1'b0;
        i_pipe_n         = '0;
        i_res_ready      = 1'b1;
        i_iter_valid     = 1'b0;
        i_iter_n         = '0;
        i_iter_res_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        compare_byte("o_res_valid", operand_t'(o_res_valid), 8'h00);
        compare_byte("o_iter_res_valid", operand_t'(o_iter_res_valid), 8'h00);
        compare_byte("o_pipe_ready", operand_t'(o_pipe_ready), 8'h01);
        compare_byte("o_iter_ready", operand_t'(o_iter_ready), 8'h01);
        compare_byte("o_disp_en", o_disp_en, 8'h00);
        compare_byte("o_disp_dot", o_disp_dot, 8'h00);

        // back-to-back stream with corner values first
        lat_check = 1'b1;
        for (int i = 0; i < PIPE_OPS; i++)
            send_pipe((i < 5) ? corner[i] : operand_t'($urandom()));
        i_pipe_valid = 1'b0;
        while (pipe_q.size() != 0)
            @(negedge clk);
        lat_check = 1'b0;
        expect_true(pipe_res_cnt == PIPE_OPS, "pipeline result count wrong after stream");

        // burst under random back-pressure
        bp_mode = 1'b1;
        for (int i = 0; i < BP_OPS; i++)
            send_pipe(operand_t'($urandom()));
        i_pipe_valid = 1'b0;
        bp_mode      = 1'b0;
        while (pipe_q.size() != 0)
            @(negedge clk);
        expect_true(pipe_res_cnt == PIPE_OPS + BP_OPS, "results lost or duplicated in burst");

        // iterative engine with random take delay
        for (int i = 0; i < ITER_OPS; i++)
        begin
            i_iter_valid = 1'b1;
            i_iter_n     = (i == 0) ? 8'hff : operand_t'($urandom());
            @(posedge clk);
            while (!o_iter_ready)
                @(posedge clk);
            @(negedge clk);
            i_iter_valid = 1'b0;
            while (!o_iter_res_valid)
                @(negedge clk);
            repeat ($urandom() % 4) @(negedge clk);
            i_iter_res_ready = 1'b1;
            @(negedge clk);
            i_iter_res_ready = 1'b0;
        end
        @(negedge clk);
        expect_true(iter_res_cnt == ITER_OPS, "iterative result count wrong");

        // single operand through an empty pipeline before reading the display
        x = operand_t'($urandom());
        send_pipe(x);
        i_pipe_valid = 1'b0;
        while (!o_res_valid)
            @(negedge clk);
        // fifth-power lane reaches the display on the next edge
        @(negedge clk);
        compare_byte("o_disp_dot", o_disp_dot, 8'h01);
        compare_byte("o_disp_en", o_disp_en, 8'hff);
        for (int k = 0; k < `POW_STAGES; k++)
            compare_byte("o_disp lane", disp_view.lane[k], pow_ref(x, MAX_POW - k));
        @(negedge clk);
        compare_byte("o_disp_dot", o_disp_dot, 8'h00);

        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verilog/disp_pkg.sv
`include "pow_config.svh"

package disp_pkg;

    // ----------------------------------------
    // display side
    // ----------------------------------------

    // one enable bit per digit, msb is the leftmost digit
    typedef logic [`DISP_DIGITS - 1:0] digit_en_t;

    // decimal points, same digit order
    typedef logic [`DISP_DIGITS - 1:0] dot_t;

endpackage

//--- verilog/pow_config.svh
`ifndef POW_CONFIG_SVH
`define POW_CONFIG_SVH

// operand and result width, results wrap modulo 2**POW_W
`define POW_W 8

// multiply stages, one per power from 2 to 5
`define POW_STAGES 4

// display digits, two per pipeline lane
`define DISP_DIGITS 8

`endif

//--- verilog/pow_disp_driver.sv
`timescale 1ns/1ps
`include "pow_config.svh"

module pow_disp_driver
    import pow_pkg::*, disp_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              i_advance,
    input  logic [`POW_STAGES - 1:0]          i_lane_valid,
    input  pow_lanes_u                        i_lanes,
    output logic [`POW_STAGES * `POW_W - 1:0] o_disp,
    output digit_en_t                         o_disp_en,
    output dot_t                              o_disp_dot
);

    localparam int S = `POW_STAGES;

    pow_lanes_u   hold_q;
    logic [S-1:0] seen_q;
    logic [S-1:0] refresh_q;
    logic [S-1:0] lane_load;

    // taps only count on cycles where the stages actually move
    assign lane_load = i_lane_valid & {S{i_advance}};

    always_ff @(posedge clk)
    begin
        for (int k = 0; k < S; k++)
            if (lane_load[k])
                hold_q.lane[k] <= i_lanes.lane[k];
    end

    // ----------------------------------------
    // sticky enables and one-shot dots
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            seen_q    <= '0;
            refresh_q <= '0;
        end
        else
        begin
            seen_q    <= seen_q | lane_load;
            refresh_q <= lane_load;
        end
    end

    // lane k drives digits 2k+1 and 2k, dot on the lower one
    always_comb
    begin
        for (int k = 0; k < S; k++)
        begin
            o_disp_en[2 * k +: 2]  = {2{seen_q[k]}};
            o_disp_dot[2 * k + 1]  = 1'b0;
            o_disp_dot[2 * k]      = refresh_q[k];
        end
    end

    assign o_disp = hold_q.flat;

endmodule

//--- verilog/pow_iterative.sv
`timescale 1ns/1ps
`include "pow_config.svh"

module pow_iterative
    import pow_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_valid,
    input  operand_t i_n,
    output logic     o_ready,
    output logic     o_res_valid,
    output operand_t o_res,
    input  logic     i_res_ready
);

    // one load step plus one step per multiply
    localparam int STEPS = `POW_STAGES + 1;

    logic [STEPS - 1:0] shift_q;
    logic               held_q;
    operand_t           n_q;
    operand_t           acc_q;
    logic               load;
    logic               mul_en;
    logic               res_taken;

    assign load      = i_valid & o_ready;
    assign mul_en    = |shift_q[STEPS - 1:1];
    assign res_taken = o_res_valid & i_res_ready;

    // ----------------------------------------
    // one-hot step counter
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            shift_q <= '0;
        else if (load)
            shift_q <= {1'b1, {(STEPS - 1){1'b0}}};
        else
            shift_q <= shift_q >> 1;
    end

    // result stays up until the consumer takes it
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            held_q <= 1'b0;
        else
            held_q <= (shift_q[0] | held_q) & ~res_taken;
    end

    // ----------------------------------------
    // shared multiplier
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            n_q   <= i_n;
            acc_q <= i_n;
        end
        else if (mul_en)
        begin
            acc_q <= acc_q * n_q;
        end
    end

    assign o_res_valid = shift_q[0] | held_q;
    assign o_res       = acc_q;
    assign o_ready     = ~(|shift_q | held_q);

endmodule

//--- verilog/pow_pipeline.sv
`timescale 1ns/1ps
`include "pow_config.svh"

module pow_pipeline
    import pow_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_valid,
    input  operand_t                  i_n,
    output logic                      o_ready,
    output logic                      o_res_valid,
    output operand_t                  o_res,
    input  logic                      i_res_ready,
    output logic                      o_advance,
    output logic [`POW_STAGES - 1:0]  o_lane_valid,
    output pow_lanes_u                o_lanes
);

    localparam int S = `POW_STAGES;

    // index 1 is the input register, index i holds the i-th power
    logic [1:S + 1] vld_q;
    operand_t       n_q   [1:S];
    operand_t       pow_q [2:S + 1];

    // ----------------------------------------
    // flow control
    // ----------------------------------------

    // whole pipe moves when the last stage is empty or drained
    assign o_advance = ~vld_q[S + 1] | i_res_ready;
    assign o_ready   = o_advance;

    // ----------------------------------------
    // valid chain
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vld_q <= '0;
        end
        else if (o_advance)
        begin
            vld_q[1] <= i_valid;
            for (int i = 1; i <= S; i++)
                vld_q[i + 1] <= vld_q[i];
        end
    end

    // ----------------------------------------
    // operand delay line and multipliers
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (o_advance)
        begin
            n_q[1] <= i_n;
            for (int i = 1; i < S; i++)
                n_q[i + 1] <= n_q[i];

            // square first, then one more factor per stage
            pow_q[2] <= n_q[1] * n_q[1];
            for (int i = 2; i <= S; i++)
                pow_q[i + 1] <= pow_q[i] * n_q[i];
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    assign o_res_valid = vld_q[S + 1];
    assign o_res       = pow_q[S + 1];

    // highest lane carries the lowest power
    always_comb
    begin
        for (int i = 2; i <= S + 1; i++)
        begin
            o_lane_valid[S + 1 - i] = vld_q[i];
            o_lanes.lane[S + 1 - i] = pow_q[i];
        end
    end

endmodule

//--- verilog/pow_pkg.sv
`include "pow_config.svh"

package pow_pkg;

    // ----------------------------------------
    // arithmetic side
    // ----------------------------------------

    // one operand or one lane value
    typedef logic [`POW_W - 1:0] operand_t;

    // result word of all lanes
    // lane 3 is the square, lane 0 the fifth power
    typedef union packed
    {
        logic [`POW_STAGES * `POW_W - 1:0] flat;
        operand_t [`POW_STAGES - 1:0]      lane;
    } pow_lanes_u;

endpackage

//--- verilog/pow_unit_top.sv
`timescale 1ns/1ps
`include "pow_config.svh"

module pow_unit_top
    import pow_pkg::*, disp_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    // pipelined engine
    input  logic                              i_pipe_valid,
    input  operand_t                          i_pipe_n,
    output logic                              o_pipe_ready,
    output logic                              o_res_valid,
    output operand_t                          o_res,
    input  logic                              i_res_ready,
    // iterative engine
    input  logic                              i_iter_valid,
    input  operand_t                          i_iter_n,
    output logic                              o_iter_ready,
    output logic                              o_iter_res_valid,
    output operand_t                          o_iter_res,
    input  logic                              i_iter_res_ready,
    // display
    output logic [`POW_STAGES * `POW_W - 1:0] o_disp,
    output digit_en_t                         o_disp_en,
    output dot_t                              o_disp_dot
);

    logic                     pipe_advance;
    logic [`POW_STAGES - 1:0] lane_valid;
    pow_lanes_u               lanes;

    pow_pipeline u_pipe
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .i_valid      ( i_pipe_valid ),
        .i_n          ( i_pipe_n     ),
        .o_ready      ( o_pipe_ready ),
        .o_res_valid  ( o_res_valid  ),
        .o_res        ( o_res        ),
        .i_res_ready  ( i_res_ready  ),
        .o_advance    ( pipe_advance ),
        .o_lane_valid ( lane_valid   ),
        .o_lanes      ( lanes        )
    );

    pow_iterative u_iter
    (
        .clk         ( clk              ),
        .rst_n       ( rst_n            ),
        .i_valid     ( i_iter_valid     ),
        .i_n         ( i_iter_n         ),
        .o_ready     ( o_iter_ready     ),
        .o_res_valid ( o_iter_res_valid ),
        .o_res       ( o_iter_res       ),
        .i_res_ready ( i_iter_res_ready )
    );

    // display follows the pipeline lanes only
    pow_disp_driver u_disp
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .i_advance    ( pipe_advance ),
        .i_lane_valid ( lane_valid   ),
        .i_lanes      ( lanes        ),
        .o_disp       ( o_disp       ),
        .o_disp_en    ( o_disp_en    ),
        .o_disp_dot   ( o_disp_dot   )
    );

endmodule
